// File: hw/coherence_pkg.sv
// MESI state encoding and the structs shared by the coherence subsystem:
// CPU port, snooping bus, snoop answer, L1 lookup, memory port, statistics.
// Address map and bus timing constants.
`default_nettype none

package coherence_pkg;

    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_t;

    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        busy;
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic        dren;     // Read for sharing
        logic        ccwrite;  // Read for ownership or upgrade
        logic        dwen;     // Memory write
        logic [31:0] daddr;
        logic [31:0] dstore;
    } bus_req_t;

    typedef struct packed {
        logic        dwait;
        logic [31:0] dload;
        logic        ccexclusive;  // No other copy exists
        logic        ccwait;       // Snoop pending for this core
        logic        ccinv;
        logic [31:0] ccsnoopaddr;
    } bus_rsp_t;

    typedef struct packed {
        logic        ccsnoopdone;
        logic        ccsnoophit;
        logic        ccdirty;
        logic [31:0] data;
    } snoop_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        snoop_req;
        mesi_t       state_transfer;
        logic [31:0] fill_data;
        logic        fill_en;
    } l1_lookup_t;

    typedef struct packed {
        logic        hit;
        mesi_t       state;
        logic        dirty;
        logic [31:0] addr;  // Address of the resident line
        logic [31:0] data;
    } l1_line_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [15:0] to_e_transitions;
        logic [15:0] to_s_transitions;
        logic [15:0] shared_blocks;
        logic [15:0] invalidated_blocks;
    } coherence_stats_t;

    localparam logic [31:0] NONCACHE_START_ADDR = 32'h8000_0000;
    localparam int          MEM_LATENCY         = 3;
    localparam int          N_CPUS              = 2;

endpackage

`default_nettype wire

// File: hw/l1_line_store.sv
// Direct-mapped L1 with one word per line: tag, MESI and data arrays.
// Serves CPU hits in the same cycle, answers lookups from the coherency unit
// and applies its fills and state changes.
`default_nettype none
`timescale 1ns/100ps

module l1_line_store
    import coherence_pkg::*;
#(
    parameter int L1_SETS = 8
) (
    input  logic       CLK,
    input  logic       nRST,
    input  cpu_req_t   cpu_req,
    output cpu_rsp_t   cpu_rsp,
    input  l1_lookup_t lookup,
    output l1_line_t   line
);
    localparam int IDX_W = $clog2(L1_SETS);
    localparam int TAG_W = 30 - IDX_W;

    logic [TAG_W-1:0] tag_arr  [L1_SETS];
    mesi_t            state_arr[L1_SETS];
    logic [31:0]      data_arr [L1_SETS];

    logic [IDX_W-1:0] cpu_idx, lk_idx;
    logic [TAG_W-1:0] cpu_tag, lk_tag;
    logic             cpu_hit, cpu_rd, cpu_wr;

    assign cpu_idx = cpu_req.addr[IDX_W+1:2];
    assign cpu_tag = cpu_req.addr[31:IDX_W+2];
    assign lk_idx  = lookup.addr[IDX_W+1:2];
    assign lk_tag  = lookup.addr[31:IDX_W+2];

    // Uncached space never hits
    assign cpu_hit = (cpu_req.addr < NONCACHE_START_ADDR) && (state_arr[cpu_idx] != INVALID)
                     && (tag_arr[cpu_idx] == cpu_tag);

    // Snoop in progress holds off the hit path
    assign cpu_rd = !lookup.snoop_req && cpu_req.ren && cpu_hit;
    assign cpu_wr = !lookup.snoop_req && cpu_req.wen && cpu_hit
                    && (state_arr[cpu_idx] == MODIFIED || state_arr[cpu_idx] == EXCLUSIVE);

    assign cpu_rsp.busy  = (cpu_req.ren || cpu_req.wen) && !(cpu_rd || cpu_wr);
    assign cpu_rsp.rdata = data_arr[cpu_idx];

    assign line.hit   = (state_arr[lk_idx] != INVALID) && (tag_arr[lk_idx] == lk_tag);
    assign line.state = state_arr[lk_idx];
    assign line.dirty = state_arr[lk_idx] == MODIFIED;
    assign line.addr  = {tag_arr[lk_idx], lk_idx, 2'b00};
    assign line.data  = data_arr[lk_idx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < L1_SETS; i++) begin
                state_arr[i] <= INVALID;
            end
        end else if (lookup.fill_en) begin
            state_arr[lk_idx] <= lookup.state_transfer;
        end else if (cpu_wr) begin
            state_arr[cpu_idx] <= MODIFIED;  // E or M write hit
        end
    end

    always_ff @(posedge CLK) begin
        if (lookup.fill_en) begin
            tag_arr[lk_idx]  <= lk_tag;
            data_arr[lk_idx] <= lookup.fill_data;
        end else if (cpu_wr) begin
            data_arr[cpu_idx] <= cpu_req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/coherency_unit.sv
// Per-core MESI coherency unit.
// Turns L1 misses, upgrades, victim writebacks and uncached accesses into
// snooping bus transactions, answers snoops and counts coherence events.
`default_nettype none
`timescale 1ns/100ps

module coherency_unit
    import coherence_pkg::*;
#(
    parameter int CPUID = 0
) (
    input  logic             CLK,
    input  logic             nRST,
    input  cpu_req_t         cpu_req,
    output cpu_rsp_t         miss_rsp,
    output l1_lookup_t       lookup,
    input  l1_line_t         line,
    output bus_req_t         bus_req,
    input  bus_rsp_t         bus_rsp[N_CPUS],
    output snoop_rsp_t       snoop_rsp,
    output coherence_stats_t stats
);
    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        WRITE_REQ,
        WRITEBACK,
        RESP_CHKTAG,
        RESP_SEND,
        RESP_FAIL
    } cu_state_t;

    cu_state_t        state, next_state;
    coherence_stats_t next_stats;
    bus_rsp_t         rsp;
    logic             active, pass_through, line_ok, victim;

    assign rsp          = bus_rsp[CPUID];  // Own slice of the bus reply
    assign active       = cpu_req.ren || cpu_req.wen;
    assign pass_through = active && (cpu_req.addr >= NONCACHE_START_ADDR);
    assign line_ok      = line.hit && (cpu_req.ren || line.state == MODIFIED
                                       || line.state == EXCLUSIVE);
    assign victim       = !line.hit && line.dirty;  // Conflicting M line

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            stats <= '0;
        end else begin
            state <= next_state;
            stats <= next_stats;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (rsp.ccwait) begin
                    next_state = RESP_CHKTAG;  // Snoop wins over CPU
                end else if (pass_through) begin
                    next_state = cpu_req.wen ? WRITEBACK : READ_REQ;
                end else if (active && !line_ok) begin
                    if (victim) begin
                        next_state = WRITEBACK;
                    end else begin
                        next_state = cpu_req.wen ? WRITE_REQ : READ_REQ;
                    end
                end
            end
            READ_REQ, WRITE_REQ, WRITEBACK: begin
                if (rsp.ccwait) begin
                    next_state = RESP_CHKTAG;
                end else if (!rsp.dwait) begin
                    next_state = IDLE;
                end
            end
            RESP_CHKTAG: next_state = line.hit ? RESP_SEND : RESP_FAIL;
            RESP_SEND, RESP_FAIL: begin
                if (!rsp.ccwait) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        next_stats            = stats;
        miss_rsp.busy         = 1'b1;
        miss_rsp.rdata        = rsp.dload;
        bus_req               = '0;
        bus_req.daddr         = cpu_req.addr;
        bus_req.dstore        = cpu_req.wdata;
        snoop_rsp             = '0;
        snoop_rsp.data        = line.data;
        lookup.addr           = cpu_req.addr;
        lookup.snoop_req      = 1'b0;
        lookup.state_transfer = INVALID;
        lookup.fill_data      = line.data;
        lookup.fill_en        = 1'b0;

        case (state)
            RESP_CHKTAG: begin
                lookup.addr           = rsp.ccsnoopaddr;
                lookup.snoop_req      = 1'b1;
                snoop_rsp.ccsnoopdone = !line.hit;  // Miss answers at once
            end
            RESP_SEND: begin
                lookup.addr           = rsp.ccsnoopaddr;
                lookup.snoop_req      = 1'b1;
                snoop_rsp.ccsnoopdone = 1'b1;
                snoop_rsp.ccsnoophit  = 1'b1;
                snoop_rsp.ccdirty     = line.dirty;
                lookup.state_transfer = rsp.ccinv ? INVALID : SHARED;
                if (!rsp.ccwait) begin
                    lookup.fill_en = 1'b1;
                    if (rsp.ccinv) begin
                        next_stats.invalidated_blocks = stats.invalidated_blocks + 16'd1;
                    end else begin
                        next_stats.shared_blocks = stats.shared_blocks + 16'd1;
                    end
                end
            end
            RESP_FAIL: begin
                lookup.addr           = rsp.ccsnoopaddr;
                lookup.snoop_req      = 1'b1;
                snoop_rsp.ccsnoopdone = 1'b1;
            end
            WRITE_REQ: begin  // I -> M and S -> M
                bus_req.ccwrite       = 1'b1;
                lookup.state_transfer = MODIFIED;
                lookup.fill_data      = cpu_req.wdata;
                lookup.fill_en        = !rsp.dwait;
                miss_rsp.busy         = rsp.dwait;
            end
            READ_REQ: begin  // I -> E or I -> S
                bus_req.dren          = 1'b1;
                lookup.state_transfer = rsp.ccexclusive ? EXCLUSIVE : SHARED;
                lookup.fill_data      = rsp.dload;
                miss_rsp.busy         = rsp.dwait;
                if (!rsp.dwait && !pass_through) begin
                    lookup.fill_en = 1'b1;
                    if (rsp.ccexclusive) begin
                        next_stats.to_e_transitions = stats.to_e_transitions + 16'd1;
                    end else begin
                        next_stats.to_s_transitions = stats.to_s_transitions + 16'd1;
                    end
                end
            end
            WRITEBACK: begin
                bus_req.dwen = 1'b1;
                if (pass_through) begin
                    miss_rsp.busy = rsp.dwait;
                end else begin
                    // Victim goes out, then the line is dropped and the miss retried
                    bus_req.daddr  = line.addr;
                    bus_req.dstore = line.data;
                    lookup.fill_en = !rsp.dwait;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/snoop_bus_ctrl.sv
// Snooping bus controller for two cores.
// Round-robin arbitration, snoop broadcast to the other core, then a memory
// read, an uncached or victim write, or a writeback of snooped dirty data.
`default_nettype none
`timescale 1ns/100ps

module snoop_bus_ctrl
    import coherence_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  bus_req_t   bus_req[N_CPUS],
    output bus_rsp_t   bus_rsp[N_CPUS],
    input  snoop_rsp_t snoop_rsp[N_CPUS],
    output bus_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_SNOOP,
        BUS_MEM
    } bus_state_t;

    bus_state_t        state;
    logic              gnt, other, pick, done;
    logic [N_CPUS-1:0] req;
    logic              snoop_hit, snoop_dirty;
    logic [31:0]       snoop_data;
    bus_req_t          cur;

    always_comb begin
        for (int i = 0; i < N_CPUS; i++) begin
            req[i] = bus_req[i].dren || bus_req[i].ccwrite || bus_req[i].dwen;
        end
    end

    assign cur   = bus_req[gnt];
    assign other = ~gnt;
    assign pick  = (req[0] && req[1]) ? ~gnt : req[1];  // Last winner yields
    assign done  = (state == BUS_MEM) && mem_rsp.ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state       <= BUS_IDLE;
            gnt         <= 1'b0;
            snoop_hit   <= 1'b0;
            snoop_dirty <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (|req) begin
                        gnt         <= pick;
                        snoop_hit   <= 1'b0;
                        snoop_dirty <= 1'b0;
                        // Writes and uncached reads need no snoop
                        if (bus_req[pick].dwen || bus_req[pick].daddr >= NONCACHE_START_ADDR) begin
                            state <= BUS_MEM;
                        end else begin
                            state <= BUS_SNOOP;
                        end
                    end
                end
                BUS_SNOOP: begin
                    if (snoop_rsp[other].ccsnoopdone) begin
                        snoop_hit   <= snoop_rsp[other].ccsnoophit;
                        snoop_dirty <= snoop_rsp[other].ccsnoophit && snoop_rsp[other].ccdirty;
                        state       <= BUS_MEM;
                    end
                end
                BUS_MEM: begin
                    if (mem_rsp.ready) begin
                        state <= BUS_IDLE;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == BUS_SNOOP && snoop_rsp[other].ccsnoopdone) begin
            snoop_data <= snoop_rsp[other].data;
        end
    end

    always_comb begin
        mem_req       = '0;
        mem_req.daddr = cur.daddr;
        if (state == BUS_MEM) begin
            if (snoop_dirty) begin
                mem_req.dwen   = 1'b1;  // Dirty copy back to memory
                mem_req.dstore = snoop_data;
            end else if (cur.dwen) begin
                mem_req.dwen   = 1'b1;
                mem_req.dstore = cur.dstore;
            end else begin
                mem_req.dren = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N_CPUS; i++) begin
            bus_rsp[i].dwait       = !(done && gnt == 1'(i));
            bus_rsp[i].dload       = snoop_dirty ? snoop_data : mem_rsp.rdata;
            bus_rsp[i].ccexclusive = !snoop_hit;
            bus_rsp[i].ccwait      = (state == BUS_SNOOP) && gnt != 1'(i);
            // Held past the snoop so the victim can apply it
            bus_rsp[i].ccinv       = (state != BUS_IDLE) && gnt != 1'(i) && cur.ccwrite;
            bus_rsp[i].ccsnoopaddr = cur.daddr;
        end
    end

endmodule

`default_nettype wire

// File: hw/shared_memory.sv
// Word-addressed backing memory with a fixed access latency
`default_nettype none
`timescale 1ns/100ps

module shared_memory
    import coherence_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t mem_req,
    output mem_rsp_t mem_rsp
);
    localparam int AW = $clog2(MEM_DEPTH);

    logic [31:0]                        mem[MEM_DEPTH];
    logic [$clog2(MEM_LATENCY+1)-1:0]   cnt;
    logic                               active;
    logic [AW-1:0]                      idx;

    assign active = mem_req.dren || mem_req.dwen;
    assign idx    = {mem_req.daddr[31], mem_req.daddr[AW:2]};  // Upper half is uncached space

    assign mem_rsp.ready = active && (cnt == MEM_LATENCY - 1);
    assign mem_rsp.rdata = mem[idx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
        end else if (!active || mem_rsp.ready) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_rsp.ready && mem_req.dwen) begin
            mem[idx] <= mem_req.dstore;
        end
    end

endmodule

`default_nettype wire

// File: hw/coherent_top.sv
// Two-core MESI subsystem: per-core L1 and coherency unit,
// snooping bus controller and shared memory
`default_nettype none
`timescale 1ns/100ps

module coherent_top
    import coherence_pkg::*;
#(
    parameter int MEM_DEPTH = 256,
    parameter int L1_SETS   = 8
) (
    input  logic             CLK,
    input  logic             nRST,
    input  cpu_req_t         cpu_req[N_CPUS],
    output cpu_rsp_t         cpu_rsp[N_CPUS],
    output coherence_stats_t stats[N_CPUS]
);
    cpu_rsp_t   hit_rsp[N_CPUS];
    cpu_rsp_t   miss_rsp[N_CPUS];
    l1_lookup_t lookup[N_CPUS];
    l1_line_t   line[N_CPUS];
    bus_req_t   bus_req[N_CPUS];
    bus_rsp_t   bus_rsp[N_CPUS];
    snoop_rsp_t snoop_rsp[N_CPUS];
    bus_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    for (genvar i = 0; i < N_CPUS; i++) begin : g_core
        l1_line_store #(.L1_SETS(L1_SETS)) u_l1 (
            .CLK, .nRST,
            .cpu_req(cpu_req[i]), .cpu_rsp(hit_rsp[i]),
            .lookup(lookup[i]), .line(line[i])
        );

        coherency_unit #(.CPUID(i)) u_cu (
            .CLK, .nRST,
            .cpu_req(cpu_req[i]), .miss_rsp(miss_rsp[i]),
            .lookup(lookup[i]), .line(line[i]),
            .bus_req(bus_req[i]), .bus_rsp(bus_rsp),
            .snoop_rsp(snoop_rsp[i]), .stats(stats[i])
        );

        // Hit path answers unless it hands off, then the coherency unit does
        assign cpu_rsp[i].busy  = hit_rsp[i].busy && miss_rsp[i].busy;
        assign cpu_rsp[i].rdata = hit_rsp[i].busy ? miss_rsp[i].rdata : hit_rsp[i].rdata;
    end

    snoop_bus_ctrl u_bus (
        .CLK, .nRST,
        .bus_req, .bus_rsp, .snoop_rsp,
        .mem_req, .mem_rsp
    );

    shared_memory #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
        .CLK, .nRST,
        .mem_req, .mem_rsp
    );

endmodule

`default_nettype wire

// File: tests/tb_coherent_top.sv
// Testbench for the two-core MESI subsystem.
// Clock and reset, CPU read and write tasks, shadow memory,
// directed coherence sequences and a random read/write mix.
`default_nettype none
`timescale 1ns/100ps

module tb_coherent_top
    import coherence_pkg::*;
();
    localparam int          L1_SETS   = 8;
    localparam int          MEM_DEPTH = 256;
    localparam int          TIMEOUT   = 100;  // Cycles per wait
    localparam int          N_OPS     = 80;
    localparam int          N_ADDRS   = 6;
    localparam logic [31:0] ADDR_A    = 32'h0000_0040;
    localparam logic [31:0] ADDR_C    = ADDR_A + L1_SETS * 4;  // Same L1 set as ADDR_A
    localparam logic [31:0] ADDR_U    = NONCACHE_START_ADDR + 32'h10;

    logic             CLK;
    logic             nRST;
    cpu_req_t         cpu_req[N_CPUS];
    cpu_rsp_t         cpu_rsp[N_CPUS];
    coherence_stats_t stats[N_CPUS];

    logic [31:0]      shadow[logic [31:0]];  // Last value written per address
    logic [31:0]      pool[N_ADDRS];
    coherence_stats_t exp_stats[N_CPUS];
    integer           seed;
    int               value_errs    = 0;
    int               timeout_errs  = 0;
    int               protocol_errs = 0;
    logic             idle_quiet;

    coherent_top #(.MEM_DEPTH(MEM_DEPTH), .L1_SETS(L1_SETS)) u_dut (
        .CLK, .nRST, .cpu_req, .cpu_rsp, .stats
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    assign idle_quiet = (cpu_req[0].ren || cpu_req[0].wen || !cpu_rsp[0].busy)
                        && (cpu_req[1].ren || cpu_req[1].wen || !cpu_rsp[1].busy);

    // An idle CPU port never reports busy
    assert property (@(negedge CLK) disable iff (!nRST) idle_quiet)
    else begin
        protocol_errs++;
        $display("ERR cpu_rsp.busy on idle port core0=%h core1=%h",
                 cpu_rsp[0].busy, cpu_rsp[1].busy);
    end

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            value_errs++;
            $display("ERR %s got=%h exp=%h", what, got, exp);
        end
    endtask

    task automatic expect_stats(input int core);
        expect_word($sformatf("stats[%0d].to_e_transitions", core),
                    {16'd0, stats[core].to_e_transitions},
                    {16'd0, exp_stats[core].to_e_transitions});
        expect_word($sformatf("stats[%0d].to_s_transitions", core),
                    {16'd0, stats[core].to_s_transitions},
                    {16'd0, exp_stats[core].to_s_transitions});
        expect_word($sformatf("stats[%0d].shared_blocks", core),
                    {16'd0, stats[core].shared_blocks},
                    {16'd0, exp_stats[core].shared_blocks});
        expect_word($sformatf("stats[%0d].invalidated_blocks", core),
                    {16'd0, stats[core].invalidated_blocks},
                    {16'd0, exp_stats[core].invalidated_blocks});
    endtask

    // Holds the request until busy drops, then releases it on the next edge
    task automatic run_request(input int core, input cpu_req_t req,
                               output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        if (core == 0) begin
            cpu_req[0] <= req;
        end else begin
            cpu_req[1] <= req;
        end
        @(negedge CLK);
        while (cpu_rsp[core].busy && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (cpu_rsp[core].busy) begin
            timeout_errs++;
            $display("Core %0d request to address %h still busy after %0d cycles",
                     core, req.addr, TIMEOUT);
        end
        rdata = cpu_rsp[core].rdata;
        @(posedge CLK);
        if (core == 0) begin
            cpu_req[0] <= '0;
        end else begin
            cpu_req[1] <= '0;
        end
        @(negedge CLK);  // Counters settled here
    endtask

    task automatic cpu_read(input int core, input logic [31:0] addr,
                            output logic [31:0] data);
        cpu_req_t req;
        req      = '0;
        req.ren  = 1'b1;
        req.addr = addr;
        run_request(core, req, data);
    endtask

    task automatic cpu_write(input int core, input logic [31:0] addr,
                             input logic [31:0] data);
        cpu_req_t    req;
        logic [31:0] ignored;
        req       = '0;
        req.wen   = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        run_request(core, req, ignored);
        shadow[addr] = data;
    endtask

    task automatic read_expect(input int core, input logic [31:0] addr);
        logic [31:0] data;
        cpu_read(core, addr, data);
        expect_word($sformatf("cpu_rsp[%0d].rdata at %h", core, addr), data, shadow[addr]);
    endtask

    initial begin
        logic [31:0] r;
        int          idx;
        int          core;
        seed = 32'h9cbcf857;
        nRST <= 1'b0;
        cpu_req[0] <= '0;
        cpu_req[1] <= '0;
        exp_stats[0] = '0;
        exp_stats[1] = '0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);

        for (int c = 0; c < N_CPUS; c++) begin  // Reset values
            expect_word($sformatf("cpu_rsp[%0d].busy", c), {31'd0, cpu_rsp[c].busy}, 32'd0);
            expect_stats(c);
        end

        // ADDR_A ends up in memory only, evicted by the write to ADDR_C
        cpu_write(1, ADDR_A, $random(seed));
        cpu_write(1, ADDR_C, $random(seed));
        expect_stats(0);
        expect_stats(1);

        read_expect(0, ADDR_A);  // No other copy, E
        exp_stats[0].to_e_transitions += 16'd1;
        expect_stats(0);
        expect_stats(1);

        read_expect(1, ADDR_A);  // Core 0 shares its E line
        exp_stats[1].to_s_transitions += 16'd1;
        exp_stats[0].shared_blocks += 16'd1;
        expect_stats(0);
        expect_stats(1);

        cpu_write(1, ADDR_A, $random(seed));  // S upgrade kills core 0 copy
        exp_stats[0].invalidated_blocks += 16'd1;
        expect_stats(0);
        expect_stats(1);

        read_expect(0, ADDR_A);  // Dirty data from core 1
        exp_stats[0].to_s_transitions += 16'd1;
        exp_stats[1].shared_blocks += 16'd1;
        expect_stats(0);
        expect_stats(1);

        // Uncached space leaves the counters alone
        cpu_write(0, ADDR_U, $random(seed));
        read_expect(1, ADDR_U);
        cpu_write(1, ADDR_U + 32'h4, $random(seed));
        read_expect(0, ADDR_U + 32'h4);
        cpu_write(0, ADDR_U, $random(seed));
        read_expect(1, ADDR_U);
        expect_stats(0);
        expect_stats(1);

        // Random mix over a small pool, one uncached entry
        for (int i = 0; i < N_ADDRS - 1; i++) begin
            r = $random(seed);
            pool[i] = {23'd0, r[6:0], 2'b00};
        end
        pool[N_ADDRS-1] = ADDR_U + 32'h8;
        for (int i = 0; i < N_ADDRS; i++) begin
            cpu_write(i % 2, pool[i], $random(seed));
        end
        for (int n = 0; n < N_OPS; n++) begin
            r    = $random(seed);
            core = int'(r[0]);
            idx  = int'(r[15:8]) % N_ADDRS;
            if (r[1]) begin
                cpu_write(core, pool[idx], $random(seed));
            end else begin
                read_expect(core, pool[idx]);
            end
        end

        $display("Errors: %0d value, %0d timeout, %0d protocol",
                 value_errs, timeout_errs, protocol_errs);
        if (value_errs + timeout_errs + protocol_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/coherence_pkg.sv
hw/l1_line_store.sv
hw/coherency_unit.sv
hw/snoop_bus_ctrl.sv
hw/shared_memory.sv
hw/coherent_top.sv
tests/tb_coherent_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench and RTL with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_coherent_top

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_coherent_top --Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
